// ==== stream_pkg.sv ====
`default_nettype none

package stream_pkg;

    //////////////////////////////////////////////////
    // stream line format
    //////////////////////////////////////////////////

    // four flag bits above the data word
    typedef logic [35:0] line_t;
    typedef logic [31:0] word_t;

    localparam int LINE_SOF_BIT = 32;
    localparam int LINE_EOF_BIT = 33;

    // framer buffer addressing
    localparam int BUF_ADDR_W = 9;
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    //////////////////////////////////////////////////
    // inspector header layout
    //////////////////////////////////////////////////

    // padded ethernet + ip + udp + vrt header
    localparam int HDR_LINES = 12;
    localparam int DSP_LINE_OFS = 11;
    typedef logic [3:0] hdr_idx_t;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;
    localparam logic [15:0] UDP_DATA_PORT = 16'd49153;

    // upper half of the framer header word
    localparam logic [15:0] FRM_HDR_TAG = 16'd1;

    // state machines
    typedef enum logic [1:0] {WAIT_SOF, WAIT_EOF, WRITE_HDR, WRITE} framer_state_e;
    typedef enum logic [1:0] {READ_PRE, READ, WRITE_REGS, WRITE_LIVE} insp_state_e;
    typedef enum logic {DEST_DSP, DEST_HOST} insp_dest_e;

endpackage

`default_nettype wire

// ==== port_crossbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_crossbar (
    input  wire               master_mode_i,
    input  wire stream_pkg::line_t ser_inp_data_i,
    input  wire               ser_inp_valid_i,
    output logic              ser_inp_ready_o,
    input  wire stream_pkg::line_t eth_inp_data_i,
    input  wire               eth_inp_valid_i,
    output logic              eth_inp_ready_o,
    output stream_pkg::line_t insp_data_o,
    output logic              insp_valid_o,
    input  wire               insp_ready_i,
    output stream_pkg::line_t xfer_data_o,
    output logic              xfer_valid_o,
    input  wire               xfer_ready_i,
    input  wire stream_pkg::line_t merged_data_i,
    input  wire               merged_valid_i,
    output logic              merged_ready_o,
    output stream_pkg::line_t ser_out_data_o,
    output logic              ser_out_valid_o,
    output stream_pkg::line_t eth_out_data_o,
    output logic              eth_out_valid_o,
    input  wire               ser_out_ready_i,
    input  wire               eth_out_ready_i
);
    import stream_pkg::*;

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    // master takes ethernet into the inspector and slave takes serdes
    assign insp_data_o = master_mode_i ? eth_inp_data_i : ser_inp_data_i;
    assign insp_valid_o = master_mode_i ? eth_inp_valid_i : ser_inp_valid_i;

    // serdes bypass into the combiner in master mode only
    assign xfer_data_o = ser_inp_data_i;
    assign xfer_valid_o = master_mode_i ? ser_inp_valid_i : 1'b0;

    // slave mode sinks the ethernet input
    assign eth_inp_ready_o = master_mode_i ? insp_ready_i : 1'b1;
    assign ser_inp_ready_o = master_mode_i ? xfer_ready_i : insp_ready_i;

    //////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////

    assign ser_out_data_o = merged_data_i;
    assign eth_out_data_o = merged_data_i;
    assign ser_out_valid_o = master_mode_i ? 1'b0 : merged_valid_i;
    assign eth_out_valid_o = master_mode_i ? merged_valid_i : 1'b0;
    assign merged_ready_o = master_mode_i ? eth_out_ready_i : ser_out_ready_i;

endmodule

`default_nettype wire

// ==== frame_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_merge (
    input  wire               stream_clk,
    input  wire               stream_rst,
    input  wire stream_pkg::line_t src0_data_i,
    input  wire               src0_valid_i,
    output logic              src0_ready_o,
    input  wire stream_pkg::line_t src1_data_i,
    input  wire               src1_valid_i,
    output logic              src1_ready_o,
    output stream_pkg::line_t out_data_o,
    output logic              out_valid_o,
    input  wire               out_ready_i
);
    import stream_pkg::*;

    logic busy;
    logic sel;
    logic prio;
    logic pick;
    logic eop;

    // source to grant from idle, the priority side wins a tie
    always_comb begin
        if (src0_valid_i && src1_valid_i) begin
            pick = prio;
        end else begin
            pick = src1_valid_i;
        end
    end

    // data path follows the held selection
    assign out_data_o = sel ? src1_data_i : src0_data_i;
    assign out_valid_o = busy & (sel ? src1_valid_i : src0_valid_i);
    assign src0_ready_o = busy & ~sel & out_ready_i;
    assign src1_ready_o = busy & sel & out_ready_i;

    assign eop = out_valid_o & out_ready_i & out_data_o[LINE_EOF_BIT];

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            busy <= 1'b0;
            sel <= 1'b0;
            prio <= 1'b0;
        end else if (!busy) begin
            if (src0_valid_i || src1_valid_i) begin
                busy <= 1'b1;
                sel <= pick;
            end
        end else if (eop) begin
            // hand priority to the other source for the next packet
            busy <= 1'b0;
            prio <= ~sel;
        end
    end

endmodule

`default_nettype wire

// ==== dsp_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_framer (
    input  wire               stream_clk,
    input  wire               stream_rst,
    input  wire stream_pkg::line_t inp_data_i,
    input  wire               inp_valid_i,
    output logic              inp_ready_o,
    output stream_pkg::line_t frm_data_o,
    output logic              frm_valid_o,
    input  wire               frm_ready_i
);
    import stream_pkg::*;

    framer_state_e state;
    buf_addr_t addr;
    buf_addr_t count;
    logic [15:0] byte_cnt;
    logic line_acc;
    logic frm_xfer;

    word_t frm_buf [2**BUF_ADDR_W];

    assign inp_ready_o = (state == WAIT_SOF) || (state == WAIT_EOF);

    // anything ahead of sof is accepted and dropped
    assign line_acc = inp_valid_i & inp_ready_o &
        ((state == WAIT_EOF) | inp_data_i[LINE_SOF_BIT]);

    assign frm_valid_o = (state == WRITE_HDR) || (state == WRITE);
    assign frm_xfer = frm_valid_o & frm_ready_i;

    // four bytes per stored line
    assign byte_cnt = {{(14-BUF_ADDR_W){1'b0}}, count, 2'b00};

    //////////////////////////////////////////////////
    // output line, header or stored word
    //////////////////////////////////////////////////

    always_comb begin
        frm_data_o = {4'b0000, frm_buf[addr]};
        if (state == WRITE_HDR) begin
            frm_data_o = {4'b0000, FRM_HDR_TAG, byte_cnt};
        end
        frm_data_o[LINE_SOF_BIT] = (state == WRITE_HDR);
        frm_data_o[LINE_EOF_BIT] = (state == WRITE) && (addr == count);
    end

    // stored lines sit at 1..count
    always_ff @(posedge stream_clk) begin
        if (line_acc) begin
            frm_buf[addr] <= inp_data_i[31:0];
        end
    end

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state <= WAIT_SOF;
            addr <= buf_addr_t'(1);
            count <= '0;
        end else begin
            case (state)
                WAIT_SOF, WAIT_EOF: begin
                    if (line_acc) begin
                        if (inp_data_i[LINE_EOF_BIT]) begin
                            count <= addr;
                            addr <= buf_addr_t'(1);
                            state <= WRITE_HDR;
                        end else begin
                            addr <= addr + buf_addr_t'(1);
                            state <= WAIT_EOF;
                        end
                    end
                end
                WRITE_HDR: begin
                    if (frm_xfer) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (frm_xfer) begin
                        if (addr == count) begin
                            addr <= buf_addr_t'(1);
                            state <= WAIT_SOF;
                        end else begin
                            addr <= addr + buf_addr_t'(1);
                        end
                    end
                end
                default: state <= WAIT_SOF;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== header_inspector.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_inspector (
    input  wire               stream_clk,
    input  wire               stream_rst,
    input  wire stream_pkg::line_t inp_data_i,
    input  wire               inp_valid_i,
    output logic              inp_ready_o,
    output stream_pkg::line_t dsp_data_o,
    output logic              dsp_valid_o,
    input  wire               dsp_ready_i,
    output stream_pkg::line_t host_data_o,
    output logic              host_valid_o,
    input  wire               host_ready_i
);
    import stream_pkg::*;

    insp_state_e state;
    insp_dest_e dest;
    hdr_idx_t idx;
    logic idx_last;
    logic reading;
    logic inp_xfer;
    logic is_data;
    line_t out_line;
    logic out_valid;
    logic out_ready;
    logic out_xfer;

    line_t hdr_regs [HDR_LINES];

    assign idx_last = (idx == hdr_idx_t'(HDR_LINES - 1));
    assign reading = (state == READ_PRE) || (state == READ);

    // ipv4, udp, data port, and the live vrt line not zero
    assign is_data = (hdr_regs[3][15:0] == ETHERTYPE_IPV4) &
        (hdr_regs[6][23:16] == IP_PROTO_UDP) &
        (hdr_regs[9][15:0] == UDP_DATA_PORT) &
        (inp_data_i[31:0] != 32'h0);

    assign out_ready = (dest == DEST_DSP) ? dsp_ready_i : host_ready_i;
    assign inp_ready_o = reading | ((state == WRITE_LIVE) & out_ready);
    assign inp_xfer = inp_valid_i & inp_ready_o;
    assign out_xfer = out_valid & out_ready;

    //////////////////////////////////////////////////
    // output line, replay or live
    //////////////////////////////////////////////////

    always_comb begin
        out_line = inp_data_i;
        out_valid = 1'b0;
        if (state == WRITE_REGS) begin
            out_line = hdr_regs[idx];
            out_valid = 1'b1;
            // dsp payload starts at the vrt line as a fresh frame
            if (dest == DEST_DSP && idx == hdr_idx_t'(DSP_LINE_OFS)) begin
                out_line[35:32] = 4'b0000;
                out_line[LINE_SOF_BIT] = 1'b1;
                out_line[LINE_EOF_BIT] = hdr_regs[idx][LINE_EOF_BIT];
            end
        end else if (state == WRITE_LIVE) begin
            out_valid = inp_valid_i;
        end
    end

    assign dsp_data_o = out_line;
    assign host_data_o = out_line;
    assign dsp_valid_o = (dest == DEST_DSP) & out_valid;
    assign host_valid_o = (dest == DEST_HOST) & out_valid;

    // header capture, pre-sof lines are not kept
    always_ff @(posedge stream_clk) begin
        if (inp_xfer && reading && (state == READ || inp_data_i[LINE_SOF_BIT])) begin
            hdr_regs[idx] <= inp_data_i;
        end
    end

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state <= READ_PRE;
            dest <= DEST_HOST;
            idx <= '0;
        end else begin
            case (state)
                READ_PRE: begin
                    if (inp_xfer && inp_data_i[LINE_SOF_BIT]) begin
                        if (inp_data_i[LINE_EOF_BIT]) begin
                            // single line packet
                            dest <= DEST_HOST;
                            state <= WRITE_REGS;
                        end else begin
                            idx <= idx + hdr_idx_t'(1);
                            state <= READ;
                        end
                    end
                end
                READ: begin
                    if (inp_xfer) begin
                        if (is_data && idx_last) begin
                            dest <= DEST_DSP;
                            idx <= hdr_idx_t'(DSP_LINE_OFS);
                            state <= WRITE_REGS;
                        end else if (inp_data_i[LINE_EOF_BIT] || idx_last) begin
                            dest <= DEST_HOST;
                            idx <= '0;
                            state <= WRITE_REGS;
                        end else begin
                            idx <= idx + hdr_idx_t'(1);
                        end
                    end
                end
                WRITE_REGS: begin
                    if (out_xfer) begin
                        if (out_line[LINE_EOF_BIT]) begin
                            idx <= '0;
                            state <= READ_PRE;
                        end else if (idx_last) begin
                            idx <= '0;
                            state <= WRITE_LIVE;
                        end else begin
                            idx <= idx + hdr_idx_t'(1);
                        end
                    end
                end
                WRITE_LIVE: begin
                    if (out_xfer && out_line[LINE_EOF_BIT]) begin
                        state <= READ_PRE;
                    end
                end
                default: state <= READ_PRE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== packet_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router (
    input  wire               stream_clk,
    input  wire               stream_rst,
    input  wire               master_mode_i,
    input  wire stream_pkg::line_t ser_inp_data_i,
    input  wire               ser_inp_valid_i,
    output logic              ser_inp_ready_o,
    input  wire stream_pkg::line_t eth_inp_data_i,
    input  wire               eth_inp_valid_i,
    output logic              eth_inp_ready_o,
    input  wire stream_pkg::line_t dsp_inp_data_i,
    input  wire               dsp_inp_valid_i,
    output logic              dsp_inp_ready_o,
    output stream_pkg::line_t ser_out_data_o,
    output logic              ser_out_valid_o,
    input  wire               ser_out_ready_i,
    output stream_pkg::line_t eth_out_data_o,
    output logic              eth_out_valid_o,
    input  wire               eth_out_ready_i,
    output stream_pkg::line_t dsp_out_data_o,
    output logic              dsp_out_valid_o,
    input  wire               dsp_out_ready_i,
    output stream_pkg::line_t host_out_data_o,
    output logic              host_out_valid_o,
    input  wire               host_out_ready_i
);
    import stream_pkg::*;

    // crossbar to inspector
    line_t insp_data;
    logic insp_valid;
    logic insp_ready;

    // serdes bypass into combiner input 1
    line_t xfer_data;
    logic xfer_valid;
    logic xfer_ready;

    // framer into combiner input 0
    line_t frm_data;
    logic frm_valid;
    logic frm_ready;

    // combiner back to the crossbar
    line_t merged_data;
    logic merged_valid;
    logic merged_ready;

    //////////////////////////////////////////////////
    // mode crossbar
    //////////////////////////////////////////////////

    port_crossbar u_crossbar (
        .master_mode_i   (master_mode_i),
        .ser_inp_data_i  (ser_inp_data_i),
        .ser_inp_valid_i (ser_inp_valid_i),
        .ser_inp_ready_o (ser_inp_ready_o),
        .eth_inp_data_i  (eth_inp_data_i),
        .eth_inp_valid_i (eth_inp_valid_i),
        .eth_inp_ready_o (eth_inp_ready_o),
        .insp_data_o     (insp_data),
        .insp_valid_o    (insp_valid),
        .insp_ready_i    (insp_ready),
        .xfer_data_o     (xfer_data),
        .xfer_valid_o    (xfer_valid),
        .xfer_ready_i    (xfer_ready),
        .merged_data_i   (merged_data),
        .merged_valid_i  (merged_valid),
        .merged_ready_o  (merged_ready),
        .ser_out_data_o  (ser_out_data_o),
        .ser_out_valid_o (ser_out_valid_o),
        .eth_out_data_o  (eth_out_data_o),
        .eth_out_valid_o (eth_out_valid_o),
        .ser_out_ready_i (ser_out_ready_i),
        .eth_out_ready_i (eth_out_ready_i)
    );

    //////////////////////////////////////////////////
    // dsp framer and output combiner
    //////////////////////////////////////////////////

    dsp_framer u_framer (
        .stream_clk  (stream_clk),
        .stream_rst  (stream_rst),
        .inp_data_i  (dsp_inp_data_i),
        .inp_valid_i (dsp_inp_valid_i),
        .inp_ready_o (dsp_inp_ready_o),
        .frm_data_o  (frm_data),
        .frm_valid_o (frm_valid),
        .frm_ready_i (frm_ready)
    );

    frame_merge u_merge (
        .stream_clk   (stream_clk),
        .stream_rst   (stream_rst),
        .src0_data_i  (frm_data),
        .src0_valid_i (frm_valid),
        .src0_ready_o (frm_ready),
        .src1_data_i  (xfer_data),
        .src1_valid_i (xfer_valid),
        .src1_ready_o (xfer_ready),
        .out_data_o   (merged_data),
        .out_valid_o  (merged_valid),
        .out_ready_i  (merged_ready)
    );

    // inspector outputs go straight to the top ports
    header_inspector u_inspector (
        .stream_clk   (stream_clk),
        .stream_rst   (stream_rst),
        .inp_data_i   (insp_data),
        .inp_valid_i  (insp_valid),
        .inp_ready_o  (insp_ready),
        .dsp_data_o   (dsp_out_data_o),
        .dsp_valid_o  (dsp_out_valid_o),
        .dsp_ready_i  (dsp_out_ready_i),
        .host_data_o  (host_out_data_o),
        .host_valid_o (host_out_valid_o),
        .host_ready_i (host_out_ready_i)
    );

endmodule

`default_nettype wire

// ==== tb_packet_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_packet_router;
    import stream_pkg::*;

    localparam int MAX_RECS = 32;
    localparam int MAX_LINES = 64;
    localparam int DRAIN_LIMIT = 400;
    localparam logic [27:0] END_REC = 28'hFFFFFFF;

    logic stream_clk;
    logic stream_rst;
    logic master_mode;

    // sources into the router
    line_t ser_inp_data;
    logic ser_inp_valid;
    logic ser_inp_ready;
    line_t eth_inp_data;
    logic eth_inp_valid;
    logic eth_inp_ready;
    line_t dsp_inp_data;
    logic dsp_inp_valid;
    logic dsp_inp_ready;

    // sinks out of the router
    line_t ser_out_data;
    logic ser_out_valid;
    logic ser_out_ready;
    line_t eth_out_data;
    logic eth_out_valid;
    logic eth_out_ready;
    line_t dsp_out_data;
    logic dsp_out_valid;
    logic dsp_out_ready;
    line_t host_out_data;
    logic host_out_valid;
    logic host_out_ready;

    // framed dsp and serdes bypass both expect lines on the merged output
    line_t exp_frm[$];
    line_t exp_byp[$];
    line_t exp_dsp[$];
    line_t exp_host[$];

    logic [27:0] trace_mem [MAX_RECS];
    line_t pkt_mem [2][MAX_LINES];
    int pkt_len [2];
    int pkt_port [2];
    int pkt_junk [2];

    logic [31:0] pay_lfsr;
    logic [31:0] rdy_lfsr;
    logic stall_en;
    logic merged_from_frm;
    int errors;
    int checks;
    int num_recs;

    packet_router dut (
        .stream_clk       (stream_clk),
        .stream_rst       (stream_rst),
        .master_mode_i    (master_mode),
        .ser_inp_data_i   (ser_inp_data),
        .ser_inp_valid_i  (ser_inp_valid),
        .ser_inp_ready_o  (ser_inp_ready),
        .eth_inp_data_i   (eth_inp_data),
        .eth_inp_valid_i  (eth_inp_valid),
        .eth_inp_ready_o  (eth_inp_ready),
        .dsp_inp_data_i   (dsp_inp_data),
        .dsp_inp_valid_i  (dsp_inp_valid),
        .dsp_inp_ready_o  (dsp_inp_ready),
        .ser_out_data_o   (ser_out_data),
        .ser_out_valid_o  (ser_out_valid),
        .ser_out_ready_i  (ser_out_ready),
        .eth_out_data_o   (eth_out_data),
        .eth_out_valid_o  (eth_out_valid),
        .eth_out_ready_i  (eth_out_ready),
        .dsp_out_data_o   (dsp_out_data),
        .dsp_out_valid_o  (dsp_out_valid),
        .dsp_out_ready_i  (dsp_out_ready),
        .host_out_data_o  (host_out_data),
        .host_out_valid_o (host_out_valid),
        .host_out_ready_i (host_out_ready)
    );

    always #2 stream_clk = ~stream_clk;

    //////////////////////////////////////////////////
    // random sources
    //////////////////////////////////////////////////

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // one lfsr step per payload bit
    function automatic word_t next_word();
        word_t w;
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            w = {w[30:0], pay_lfsr[0]};
            pay_lfsr = galois_step(pay_lfsr);
        end
        return w;
    endfunction

    // ready three cycles in four on average
    function automatic logic next_ready();
        logic [1:0] b;
        b[0] = rdy_lfsr[0];
        rdy_lfsr = galois_step(rdy_lfsr);
        b[1] = rdy_lfsr[0];
        rdy_lfsr = galois_step(rdy_lfsr);
        return |b;
    endfunction

    always @(posedge stream_clk) begin : sink_ready_drive
        logic stall_now;
        stall_now = stall_en;
        #1;
        ser_out_ready = stall_now ? next_ready() : 1'b1;
        eth_out_ready = stall_now ? next_ready() : 1'b1;
        dsp_out_ready = stall_now ? next_ready() : 1'b1;
        host_out_ready = stall_now ? next_ready() : 1'b1;
    end

    //////////////////////////////////////////////////
    // packet build and drive
    //////////////////////////////////////////////////

    task automatic build_packet(input int slot, input logic [27:0] rec);
        int len;
        int kind;
        int i;
        logic inspected;
        word_t w;
        line_t ln;
        len = int'(rec[19:8]);
        kind = int'(rec[7:4]);
        pkt_port[slot] = int'(rec[23:20]);
        pkt_len[slot] = len;
        pkt_junk[slot] = (pkt_port[slot] == 2) ? kind : 0;
        // slave inspects serdes and master inspects ethernet
        inspected = (pkt_port[slot] == int'(rec[24]));
        for (i = 0; i < len; i++) begin
            w = next_word();
            // short packets carry whatever header fields fit
            if (inspected) begin
                case (i)
                    3: w[15:0] = ETHERTYPE_IPV4;
                    6: w[23:16] = IP_PROTO_UDP;
                    9: w[15:0] = (kind == 1) ? UDP_DATA_PORT + 16'd1 : UDP_DATA_PORT;
                    11: w = (kind == 2) ? 32'h0 : (w | 32'h1);
                    default: ;
                endcase
            end
            pkt_mem[slot][i] = {2'b00, (i == len - 1), (i == 0), w};
        end
        if (pkt_port[slot] == 2) begin
            exp_frm.push_back({2'b00, 1'b0, 1'b1, FRM_HDR_TAG, 16'(4 * len)});
            for (i = 0; i < len; i++) begin
                exp_frm.push_back({2'b00, (i == len - 1), 1'b0, pkt_mem[slot][i][31:0]});
            end
        end else if (inspected && kind == 0) begin
            // vrt line opens a fresh frame with sof only
            ln = pkt_mem[slot][DSP_LINE_OFS];
            ln[35:32] = 4'b0001;
            exp_dsp.push_back(ln);
            for (i = DSP_LINE_OFS + 1; i < len; i++) begin
                exp_dsp.push_back(pkt_mem[slot][i]);
            end
        end else if (inspected) begin
            for (i = 0; i < len; i++) begin
                exp_host.push_back(pkt_mem[slot][i]);
            end
        end else if (rec[24]) begin
            for (i = 0; i < len; i++) begin
                exp_byp.push_back(pkt_mem[slot][i]);
            end
        end
    endtask

    task automatic put_line(input int port, input line_t ln, input logic vld);
        case (port)
            0: begin
                ser_inp_data = ln;
                ser_inp_valid = vld;
            end
            1: begin
                eth_inp_data = ln;
                eth_inp_valid = vld;
            end
            default: begin
                dsp_inp_data = ln;
                dsp_inp_valid = vld;
            end
        endcase
    endtask

    function automatic logic port_ready(input int port);
        case (port)
            0: return ser_inp_ready;
            1: return eth_inp_ready;
            default: return dsp_inp_ready;
        endcase
    endfunction

    task automatic send_packet(input int slot);
        int i;
        line_t ln;
        for (i = -pkt_junk[slot]; i < pkt_len[slot]; i++) begin
            // lines ahead of sof carry no flags
            ln = (i < 0) ? {4'b0000, ~pkt_mem[slot][0][31:0]} : pkt_mem[slot][i];
            put_line(pkt_port[slot], ln, 1'b1);
            do begin
                @(negedge stream_clk);
            end while (!port_ready(pkt_port[slot]));
            @(posedge stream_clk);
            #1;
        end
        put_line(pkt_port[slot], '0, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // output scoreboards
    //////////////////////////////////////////////////

    task automatic compare_line(input string name, input line_t exp_ln, input line_t got_ln);
        checks++;
        assert (got_ln === exp_ln) else begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp_ln, got_ln);
            errors++;
        end
    endtask

    task automatic report_extra(input string name, input int avail);
        assert (avail > 0) else begin
            $display("unexpected line on %s at %0t, nothing was due there", name, $time);
            errors++;
        end
    endtask

    always @(negedge stream_clk) begin : output_monitor
        line_t m_data;
        logic m_xfer;
        string m_name;
        if (!stream_rst) begin
            m_data = master_mode ? eth_out_data : ser_out_data;
            m_xfer = master_mode ? (eth_out_valid & eth_out_ready)
                                 : (ser_out_valid & ser_out_ready);
            m_name = master_mode ? "eth_out_data" : "ser_out_data";
            assert (!(master_mode ? ser_out_valid : eth_out_valid)) else begin
                $display("unused combiner output went valid at %0t", $time);
                errors++;
            end
            if (m_xfer) begin
                // a frame start tells which source the packet came from
                if (m_data[LINE_SOF_BIT]) begin
                    merged_from_frm = (exp_frm.size() > 0) && (exp_frm[0] === m_data);
                end
                if (merged_from_frm) begin
                    report_extra(m_name, exp_frm.size());
                    if (exp_frm.size() > 0) begin
                        compare_line(m_name, exp_frm.pop_front(), m_data);
                    end
                end else begin
                    report_extra(m_name, exp_byp.size());
                    if (exp_byp.size() > 0) begin
                        compare_line(m_name, exp_byp.pop_front(), m_data);
                    end
                end
            end
            if (dsp_out_valid && dsp_out_ready) begin
                report_extra("dsp_out_data", exp_dsp.size());
                if (exp_dsp.size() > 0) begin
                    compare_line("dsp_out_data", exp_dsp.pop_front(), dsp_out_data);
                end
            end
            if (host_out_valid && host_out_ready) begin
                report_extra("host_out_data", exp_host.size());
                if (exp_host.size() > 0) begin
                    compare_line("host_out_data", exp_host.pop_front(), host_out_data);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        wait (num_recs > 0);
        #((40 * num_recs + 200) * 4);
        $display("watchdog expired after %0d cycles, the run did not finish",
            40 * num_recs + 200);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int r;
        int n_pkts;
        int err_start;
        int wait_cnt;
        int test_no;
        stream_clk = 1'b0;
        stream_rst = 1'b1;
        master_mode = 1'b0;
        put_line(0, '0, 1'b0);
        put_line(1, '0, 1'b0);
        put_line(2, '0, 1'b0);
        ser_out_ready = 1'b1;
        eth_out_ready = 1'b1;
        dsp_out_ready = 1'b1;
        host_out_ready = 1'b1;
        stall_en = 1'b0;
        merged_from_frm = 1'b0;
        pay_lfsr = 32'he7b1;
        rdy_lfsr = 32'he7b1;
        errors = 0;
        checks = 0;
        num_recs = 0;
        test_no = 0;
        for (r = 0; r < MAX_RECS; r++) begin
            trace_mem[r] = END_REC;
        end
        $readmemh("router_trace.txt", trace_mem);
        while (num_recs < MAX_RECS && trace_mem[num_recs] !== END_REC) begin
            num_recs++;
        end
        assert (num_recs > 0) else begin
            $display("trace file held no test records");
            errors++;
        end

        repeat (2) @(posedge stream_clk);
        #1;
        stream_rst = 1'b0;
        @(negedge stream_clk);
        assert (!ser_out_valid && !eth_out_valid && !dsp_out_valid && !host_out_valid)
        else begin
            $display("an output was valid right after reset");
            errors++;
        end
        assert (dsp_inp_ready && ser_inp_ready) else begin
            $display("dsp or serdes input was not ready right after reset");
            errors++;
        end

        r = 0;
        while (r < num_recs) begin
            // flag bit 1 runs this record together with the next one
            n_pkts = (trace_mem[r][1] && r + 1 < num_recs) ? 2 : 1;
            err_start = errors;
            @(posedge stream_clk);
            #1;
            master_mode = trace_mem[r][24];
            stall_en = trace_mem[r][0];
            build_packet(0, trace_mem[r]);
            if (n_pkts == 2) begin
                build_packet(1, trace_mem[r + 1]);
                fork
                    send_packet(0);
                    send_packet(1);
                join
            end else begin
                send_packet(0);
            end
            wait_cnt = 0;
            while (exp_frm.size() + exp_byp.size() + exp_dsp.size() + exp_host.size() > 0
                && wait_cnt < DRAIN_LIMIT) begin
                @(posedge stream_clk);
                wait_cnt++;
            end
            if (wait_cnt >= DRAIN_LIMIT) begin
                $display("test %0d timed out with expected output still missing", test_no);
                errors++;
                exp_frm.delete();
                exp_byp.delete();
                exp_dsp.delete();
                exp_host.delete();
            end
            // idle gap lets stray output show up before the next test
            repeat (8) @(posedge stream_clk);
            $display("test %0d records %0d..%0d mode %0d: %0d new errors",
                test_no, r, r + n_pkts - 1, master_mode, errors - err_start);
            test_no++;
            r = r + n_pkts;
        end

        $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== router_trace.txt ====
// hex digits: mode(1) port(1) lines(3) kind(1) flags(1); port 0 serdes 1 ethernet 2 dsp
// kind 0 data 1 wrong port 2 zero vrt 3 short, dsp kind = pre-sof lines; flags 1 stall 2 pair
0200800
0201011
0001000
0000E11
0000D20
0000530
0100600
1101101
1100930
1100F20
1000A02
1200C00
1200603
1000700
FFFFFFF

// ==== sim.f ====
stream_pkg.sv
port_crossbar.sv
frame_merge.sv
dsp_framer.sv
header_inspector.sv
packet_router.sv
tb_packet_router.sv
